// ==== hw/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// 32-bit byte address splits as tag, set, line offset
`define LINE_OFFSET_BITS 5
`define SET_BITS 4
`define TAG_BITS 23

// 64-bit beats per cacheline
`define BURST_BEATS 4

`endif

// ==== hw/cache_types_pkg.sv ====
`include "mem_macros.svh"

package cache_types_pkg;

    // word 0 lives in the low bits
    typedef logic [(8 << `LINE_OFFSET_BITS)-1:0] cacheline_t;

    typedef enum logic [2:0] {
        CACHE_IDLE,
        CACHE_LOOKUP,    // tag compare
        CACHE_WRITEBACK, // dirty victim going out
        CACHE_FILL,
        CACHE_RESPOND
    } cache_state_e;

endpackage

// ==== hw/mem_bus_pkg.sv ====
`include "mem_macros.svh"

package mem_bus_pkg;

    typedef logic [(8 << `LINE_OFFSET_BITS) / `BURST_BEATS - 1:0] burst_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DATA,  // dcache owns the line channel
        ARB_INSTR
    } arb_state_e;

    typedef enum logic [1:0] {
        ADP_IDLE,
        ADP_READ,
        ADP_WRITE,
        ADP_DONE   // one-cycle resp back upstream
    } adaptor_state_e;

endpackage

// ==== hw/icache.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module icache (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [31:0]                 imem_address_i,
    input  logic                        imem_read_i,
    output logic [31:0]                 imem_rdata_o,
    output logic                        imem_resp_o,
    output logic [31:0]                 line_address_o,
    output logic                        line_read_o,
    input  cache_types_pkg::cacheline_t line_rdata_i,
    input  logic                        line_resp_i,
    output logic                        hit_o,
    output logic                        miss_o
);
    import cache_types_pkg::*;

    localparam int NUM_SETS = 1 << `SET_BITS;

    cache_state_e state, next_state;

    cacheline_t           data_array [NUM_SETS];
    logic [`TAG_BITS-1:0] tag_array  [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_q;

    logic [`TAG_BITS-1:0] tag;
    logic [`SET_BITS-1:0] set_idx;
    logic [2:0]           word_sel;
    logic                 tag_match;
    logic                 fill_done;

    assign tag       = imem_address_i[31 -: `TAG_BITS];
    assign set_idx   = imem_address_i[`LINE_OFFSET_BITS +: `SET_BITS];
    assign word_sel  = imem_address_i[`LINE_OFFSET_BITS-1:2];
    assign tag_match = valid_q[set_idx] && (tag_array[set_idx] == tag);
    assign fill_done = (state == CACHE_FILL) && line_resp_i;

    assign hit_o  = (state == CACHE_LOOKUP) && tag_match;
    assign miss_o = (state == CACHE_LOOKUP) && !tag_match;

    assign imem_resp_o  = (state == CACHE_RESPOND);
    assign imem_rdata_o = data_array[set_idx][word_sel*32 +: 32]; // address held until resp

    assign line_read_o    = (state == CACHE_FILL);
    assign line_address_o = {tag, set_idx, {`LINE_OFFSET_BITS{1'b0}}};

    always_comb begin
        next_state = state;
        unique case (state)
            CACHE_IDLE: begin
                if (imem_read_i)
                    next_state = CACHE_LOOKUP;
            end
            CACHE_LOOKUP: begin
                next_state = tag_match ? CACHE_RESPOND : CACHE_FILL;
            end
            CACHE_FILL: begin
                if (line_resp_i)
                    next_state = CACHE_RESPOND;
            end
            default: next_state = CACHE_IDLE; // respond lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state   <= CACHE_IDLE;
            valid_q <= '0;
        end else begin
            state <= next_state;
            if (fill_done)
                valid_q[set_idx] <= 1'b1;
        end
    end

    // install the fetched line
    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_array[set_idx] <= line_rdata_i;
            tag_array[set_idx]  <= tag;
        end
    end

endmodule : icache

// ==== hw/dcache.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module dcache (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [31:0]                 dmem_address_i,
    input  logic                        dmem_read_i,
    input  logic                        dmem_write_i,
    input  logic [3:0]                  dmem_wmask_i,
    input  logic [31:0]                 dmem_wdata_i,
    output logic [31:0]                 dmem_rdata_o,
    output logic                        dmem_resp_o,
    output logic [31:0]                 line_address_o,
    output logic                        line_read_o,
    output logic                        line_write_o,
    output cache_types_pkg::cacheline_t line_wdata_o,
    input  cache_types_pkg::cacheline_t line_rdata_i,
    input  logic                        line_resp_i,
    output logic                        hit_o,
    output logic                        miss_o
);
    import cache_types_pkg::*;

    localparam int NUM_SETS = 1 << `SET_BITS;

    cache_state_e state, next_state;

    cacheline_t           data_array [NUM_SETS];
    logic [`TAG_BITS-1:0] tag_array  [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_q;
    logic [NUM_SETS-1:0]  dirty_q;

    logic [`TAG_BITS-1:0] tag;
    logic [`SET_BITS-1:0] set_idx;
    logic [2:0]           word_sel;
    logic                 tag_match;
    logic                 victim_dirty;
    logic                 fill_done;
    logic                 write_hit;

    // replace only the masked bytes of one word
    function automatic cacheline_t merge_word(input cacheline_t line, input logic [2:0] word,
                                              input logic [31:0] wdata, input logic [3:0] mask);
        cacheline_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                merged[word*32 + b*8 +: 8] = wdata[b*8 +: 8];
        end
        return merged;
    endfunction

    assign tag          = dmem_address_i[31 -: `TAG_BITS];
    assign set_idx      = dmem_address_i[`LINE_OFFSET_BITS +: `SET_BITS];
    assign word_sel     = dmem_address_i[`LINE_OFFSET_BITS-1:2];
    assign tag_match    = valid_q[set_idx] && (tag_array[set_idx] == tag);
    assign victim_dirty = valid_q[set_idx] && dirty_q[set_idx];
    assign fill_done    = (state == CACHE_FILL) && line_resp_i;

    assign hit_o     = (state == CACHE_LOOKUP) && tag_match;
    assign miss_o    = (state == CACHE_LOOKUP) && !tag_match;
    assign write_hit = hit_o && dmem_write_i;

    assign dmem_resp_o  = (state == CACHE_RESPOND);
    assign dmem_rdata_o = data_array[set_idx][word_sel*32 +: 32]; // merged word after a write

    assign line_read_o  = (state == CACHE_FILL);
    assign line_write_o = (state == CACHE_WRITEBACK);
    assign line_wdata_o = data_array[set_idx];

    // victim address comes from the stored tag
    assign line_address_o = (state == CACHE_WRITEBACK) ?
                            {tag_array[set_idx], set_idx, {`LINE_OFFSET_BITS{1'b0}}} :
                            {tag, set_idx, {`LINE_OFFSET_BITS{1'b0}}};

    always_comb begin
        next_state = state;
        unique case (state)
            CACHE_IDLE: begin
                if (dmem_read_i || dmem_write_i)
                    next_state = CACHE_LOOKUP;
            end
            CACHE_LOOKUP: begin
                if (tag_match)
                    next_state = CACHE_RESPOND;
                else if (victim_dirty)
                    next_state = CACHE_WRITEBACK;
                else
                    next_state = CACHE_FILL;
            end
            CACHE_WRITEBACK: begin
                if (line_resp_i)
                    next_state = CACHE_FILL; // fill is a separate transaction
            end
            CACHE_FILL: begin
                if (line_resp_i)
                    next_state = CACHE_RESPOND;
            end
            default: next_state = CACHE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state   <= CACHE_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state <= next_state;
            if (fill_done) begin
                valid_q[set_idx] <= 1'b1;
                dirty_q[set_idx] <= dmem_write_i; // write-allocate
            end else if (write_hit) begin
                dirty_q[set_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_array[set_idx] <= tag;
            if (dmem_write_i)
                data_array[set_idx] <= merge_word(line_rdata_i, word_sel,
                                                  dmem_wdata_i, dmem_wmask_i);
            else
                data_array[set_idx] <= line_rdata_i;
        end else if (write_hit) begin
            data_array[set_idx] <= merge_word(data_array[set_idx], word_sel,
                                              dmem_wdata_i, dmem_wmask_i);
        end
    end

endmodule : dcache

// ==== hw/cache_arbiter.sv ====
`timescale 1ns/1ps

module cache_arbiter (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [31:0]                 icache_address_i,
    input  logic                        icache_read_i,
    output cache_types_pkg::cacheline_t icache_rdata_o,
    output logic                        icache_resp_o,
    input  logic [31:0]                 dcache_address_i,
    input  logic                        dcache_read_i,
    input  logic                        dcache_write_i,
    input  cache_types_pkg::cacheline_t dcache_wdata_i,
    output cache_types_pkg::cacheline_t dcache_rdata_o,
    output logic                        dcache_resp_o,
    output logic [31:0]                 mem_address_o,
    output logic                        mem_read_o,
    output logic                        mem_write_o,
    output cache_types_pkg::cacheline_t mem_wdata_o,
    input  cache_types_pkg::cacheline_t mem_rdata_i,
    input  logic                        mem_resp_i
);
    import mem_bus_pkg::*;

    arb_state_e state, next_state;

    always_comb begin
        next_state = state;
        unique case (state)
            ARB_IDLE: begin
                if (dcache_read_i || dcache_write_i)
                    next_state = ARB_DATA;  // data side wins a tie
                else if (icache_read_i)
                    next_state = ARB_INSTR;
            end
            ARB_DATA, ARB_INSTR: begin
                if (mem_resp_i)
                    next_state = ARB_IDLE;
            end
            default: next_state = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i)
            state <= ARB_IDLE;
        else
            state <= next_state;
    end

    // forward only the owner's request
    always_comb begin
        mem_address_o = dcache_address_i;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;
        if (state == ARB_DATA) begin
            mem_read_o  = dcache_read_i;
            mem_write_o = dcache_write_i;
        end else if (state == ARB_INSTR) begin
            mem_address_o = icache_address_i;
            mem_read_o    = icache_read_i;
        end
    end

    assign mem_wdata_o = dcache_wdata_i; // icache never writes

    assign dcache_rdata_o = mem_rdata_i;
    assign icache_rdata_o = mem_rdata_i;
    assign dcache_resp_o  = (state == ARB_DATA) && mem_resp_i;
    assign icache_resp_o  = (state == ARB_INSTR) && mem_resp_i;

endmodule : cache_arbiter

// ==== hw/cacheline_adaptor.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module cacheline_adaptor (
    input  logic                        clk,
    input  logic                        reset_i,
    input  cache_types_pkg::cacheline_t line_i,
    output cache_types_pkg::cacheline_t line_o,
    input  logic [31:0]                 address_i,
    input  logic                        read_i,
    input  logic                        write_i,
    output logic                        resp_o,
    input  mem_bus_pkg::burst_t         burst_i,
    output mem_bus_pkg::burst_t         burst_o,
    output logic [31:0]                 address_o,
    output logic                        read_o,
    output logic                        write_o,
    input  logic                        resp_i
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int BEAT_BITS = $bits(burst_t);
    localparam int LINE_BITS = $bits(cacheline_t);

    adaptor_state_e state, next_state;

    cacheline_t  line_q;
    logic [31:0] address_q;
    logic [1:0]  beat_cnt;
    logic        last_beat;

    assign last_beat = resp_i && (beat_cnt == 2'(`BURST_BEATS - 1));

    always_comb begin
        next_state = state;
        unique case (state)
            ADP_IDLE: begin
                if (read_i)
                    next_state = ADP_READ;
                else if (write_i)
                    next_state = ADP_WRITE;
            end
            ADP_READ, ADP_WRITE: begin
                if (last_beat)
                    next_state = ADP_DONE;
            end
            default: next_state = ADP_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= ADP_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == ADP_IDLE)
                beat_cnt <= '0;
            else if (resp_i && (state == ADP_READ || state == ADP_WRITE))
                beat_cnt <= beat_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ADP_IDLE) begin
            address_q <= address_i;
            line_q    <= line_i;   // overwritten by beats on a read
        end else if (state == ADP_READ && resp_i) begin
            line_q <= {burst_i, line_q[LINE_BITS-1:BEAT_BITS]}; // lowest beat ends up low
        end
    end

    assign read_o    = (state == ADP_READ);
    assign write_o   = (state == ADP_WRITE);
    assign address_o = address_q;
    assign burst_o   = line_q[beat_cnt*BEAT_BITS +: BEAT_BITS];
    assign line_o    = line_q;
    assign resp_o    = (state == ADP_DONE);

endmodule : cacheline_adaptor

// ==== hw/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [31:0]         imem_address_i,
    input  logic                imem_read_i,
    output logic [31:0]         imem_rdata_o,
    output logic                imem_resp_o,
    input  logic [31:0]         dmem_address_i,
    input  logic                dmem_read_i,
    input  logic                dmem_write_i,
    input  logic [3:0]          dmem_wmask_i,
    input  logic [31:0]         dmem_wdata_i,
    output logic [31:0]         dmem_rdata_o,
    output logic                dmem_resp_o,
    output logic [31:0]         bmem_address_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_bus_pkg::burst_t bmem_wdata_o,
    input  mem_bus_pkg::burst_t bmem_rdata_i,
    input  logic                bmem_resp_i,
    output logic                i_hit_o,
    output logic                i_miss_o,
    output logic                d_hit_o,
    output logic                d_miss_o
);
    import cache_types_pkg::*;

    // icache to arbiter
    logic [31:0] i_line_address;
    logic        i_line_read, i_line_resp;
    cacheline_t  i_line_rdata;

    // dcache to arbiter
    logic [31:0] d_line_address;
    logic        d_line_read, d_line_write, d_line_resp;
    cacheline_t  d_line_rdata, d_line_wdata;

    // arbiter to adaptor
    logic [31:0] a_line_address;
    logic        a_line_read, a_line_write, a_line_resp;
    cacheline_t  a_line_rdata, a_line_wdata;

    icache icache_i (
        .clk(clk), .reset_i(reset_i),
        .imem_address_i(imem_address_i), .imem_read_i(imem_read_i),
        .imem_rdata_o(imem_rdata_o), .imem_resp_o(imem_resp_o),
        .line_address_o(i_line_address), .line_read_o(i_line_read),
        .line_rdata_i(i_line_rdata), .line_resp_i(i_line_resp),
        .hit_o(i_hit_o), .miss_o(i_miss_o)
    );

    dcache dcache_i (
        .clk(clk), .reset_i(reset_i),
        .dmem_address_i(dmem_address_i), .dmem_read_i(dmem_read_i),
        .dmem_write_i(dmem_write_i), .dmem_wmask_i(dmem_wmask_i),
        .dmem_wdata_i(dmem_wdata_i), .dmem_rdata_o(dmem_rdata_o),
        .dmem_resp_o(dmem_resp_o),
        .line_address_o(d_line_address), .line_read_o(d_line_read),
        .line_write_o(d_line_write), .line_wdata_o(d_line_wdata),
        .line_rdata_i(d_line_rdata), .line_resp_i(d_line_resp),
        .hit_o(d_hit_o), .miss_o(d_miss_o)
    );

    cache_arbiter arbiter_i (
        .clk(clk), .reset_i(reset_i),
        .icache_address_i(i_line_address), .icache_read_i(i_line_read),
        .icache_rdata_o(i_line_rdata), .icache_resp_o(i_line_resp),
        .dcache_address_i(d_line_address), .dcache_read_i(d_line_read),
        .dcache_write_i(d_line_write), .dcache_wdata_i(d_line_wdata),
        .dcache_rdata_o(d_line_rdata), .dcache_resp_o(d_line_resp),
        .mem_address_o(a_line_address), .mem_read_o(a_line_read),
        .mem_write_o(a_line_write), .mem_wdata_o(a_line_wdata),
        .mem_rdata_i(a_line_rdata), .mem_resp_i(a_line_resp)
    );

    cacheline_adaptor adaptor_i (
        .clk(clk), .reset_i(reset_i),
        .line_i(a_line_wdata), .line_o(a_line_rdata),
        .address_i(a_line_address), .read_i(a_line_read),
        .write_i(a_line_write), .resp_o(a_line_resp),
        .burst_i(bmem_rdata_i), .burst_o(bmem_wdata_o),
        .address_o(bmem_address_o), .read_o(bmem_read_o),
        .write_o(bmem_write_o), .resp_i(bmem_resp_i)
    );

endmodule : mem_subsystem

// ==== testbench/mem_subsystem_checker.sv ====
`timescale 1ns/1ps

module mem_subsystem_checker (
    input logic        clk,
    input logic        reset_i,
    input logic [31:0] bmem_address_i,
    input logic        bmem_read_i,
    input logic        bmem_write_i,
    input logic        imem_resp_i,
    input logic        dmem_resp_i,
    input logic        i_hit_i,
    input logic        i_miss_i,
    input logic        d_hit_i,
    input logic        d_miss_i
);
    int assert_fails = 0; // failed assertions so far

    bmem_one_direction: assert property (@(posedge clk) disable iff (reset_i)
        !(bmem_read_i && bmem_write_i))
        else begin
            $error("bmem read and write high in the same cycle");
            assert_fails++;
        end

    icache_hit_or_miss: assert property (@(posedge clk) disable iff (reset_i)
        !(i_hit_i && i_miss_i))
        else begin
            $error("icache hit and miss high together");
            assert_fails++;
        end

    dcache_hit_or_miss: assert property (@(posedge clk) disable iff (reset_i)
        !(d_hit_i && d_miss_i))
        else begin
            $error("dcache hit and miss high together");
            assert_fails++;
        end

    // bursts always cover one whole line
    bmem_line_aligned: assert property (@(posedge clk) disable iff (reset_i)
        (bmem_read_i || bmem_write_i) |-> (bmem_address_i[4:0] == 5'd0))
        else begin
            $error("bmem address not aligned to a 32-byte line");
            assert_fails++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        reset_i |=> !(bmem_read_i || bmem_write_i || imem_resp_i || dmem_resp_i ||
                      i_hit_i || i_miss_i || d_hit_i || d_miss_i))
        else begin
            $error("output high in the cycle after reset");
            assert_fails++;
        end

endmodule : mem_subsystem_checker

bind mem_subsystem mem_subsystem_checker checker_i (
    .clk(clk), .reset_i(reset_i),
    .bmem_address_i(bmem_address_o), .bmem_read_i(bmem_read_o),
    .bmem_write_i(bmem_write_o),
    .imem_resp_i(imem_resp_o), .dmem_resp_i(dmem_resp_o),
    .i_hit_i(i_hit_o), .i_miss_i(i_miss_o),
    .d_hit_i(d_hit_o), .d_miss_i(d_miss_o)
);

// ==== testbench/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int TIMEOUT_CYCLES = 500;
    localparam int MEM_WORDS      = 1024;

    typedef struct {
        byte         port;
        byte         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
        logic [31:0] word;
        logic [31:0] hit;
        int          line_no;
    } access_t;

    logic        clk            = 1'b0;
    logic        reset_i        = 1'b1;
    logic [31:0] imem_address_i = '0;
    logic        imem_read_i    = 1'b0;
    logic [31:0] dmem_address_i = '0;
    logic        dmem_read_i    = 1'b0;
    logic        dmem_write_i   = 1'b0;
    logic [3:0]  dmem_wmask_i   = '0;
    logic [31:0] dmem_wdata_i   = '0;
    logic [63:0] bmem_rdata_i   = '0;
    logic        bmem_resp_i    = 1'b0;
    logic [31:0] imem_rdata_o, dmem_rdata_o, bmem_address_o;
    logic        imem_resp_o, dmem_resp_o, bmem_read_o, bmem_write_o;
    logic [63:0] bmem_wdata_o;
    logic        i_hit_o, i_miss_o, d_hit_o, d_miss_o;

    logic [31:0] mem_q   [MEM_WORDS]; // burst memory behind the adaptor
    logic [31:0] ref_mem [MEM_WORDS]; // processor view of memory
    logic [22:0] i_tag_m [16];
    logic [22:0] d_tag_m [16];
    logic [15:0] i_valid_m = '0;
    logic [15:0] d_valid_m = '0;
    logic [31:0] lfsr_q    = 32'h684c;
    int unsigned gap_left  = 0;
    int unsigned beat_idx  = 0;
    access_t     accesses[$];

    mem_subsystem dut_i (.*);

    always #20 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    endtask

    // taps 32, 22, 2, 1
    function automatic logic random_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic int unsigned draw_delay();
        logic [1:0] d;
        d[1] = random_bit();
        d[0] = random_bit();
        return d;
    endfunction

    // one beat per resp with 0 to 3 idle cycles before each
    always @(negedge clk) begin
        logic [9:0] w;
        bmem_resp_i = 1'b0;
        if (reset_i) begin
            beat_idx = 0;
        end else if (bmem_read_o || bmem_write_o) begin
            if (bmem_address_o >= 32'(MEM_WORDS * 4))
                fail_run("burst memory access outside the modelled range");
            if (gap_left != 0) begin
                gap_left--;
            end else begin
                w = 10'((bmem_address_o >> 2) + beat_idx * 2);
                if (bmem_write_o) begin
                    mem_q[w]     = bmem_wdata_o[31:0];
                    mem_q[w + 1] = bmem_wdata_o[63:32];
                end else begin
                    bmem_rdata_i = {mem_q[w + 1], mem_q[w]}; // low word first
                end
                bmem_resp_i = 1'b1;
                beat_idx    = (beat_idx + 1) % 4;
                gap_left    = draw_delay();
            end
        end
    end

    always @(negedge clk) begin
        if (dut_i.checker_i.assert_fails != 0)
            fail_run("a protocol assertion in the bound checker failed");
    end

    task automatic load_golden();
        int      fd;
        int      line_no;
        int      fields;
        string   text;
        access_t acc;
        fd = $fopen("testbench/mem_subsystem_golden.txt", "r");
        if (fd == 0)
            fail_run("cannot open the golden file");
        line_no = 0;
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            line_no++;
            if (text.len() < 2 || text.getc(0) == "#")
                continue;
            fields = $sscanf(text, "%c %c %h %h %h %h %d", acc.port, acc.op, acc.addr,
                             acc.wdata, acc.mask, acc.word, acc.hit);
            if (fields != 7 || acc.addr >= 32'(MEM_WORDS * 4))
                fail_run($sformatf("golden file line %0d is malformed", line_no));
            acc.line_no = line_no;
            accesses.push_back(acc);
        end
        $fclose(fd);
    endtask

    // tag model and expected word checked against the golden file
    task automatic verify_model(input access_t acc);
        logic [3:0]  set_idx;
        logic [22:0] tag;
        logic [9:0]  idx;
        logic [31:0] hit;
        set_idx = acc.addr[8:5];
        tag     = acc.addr[31:9];
        idx     = acc.addr[11:2];
        if (acc.port == "I") begin
            hit = 32'(i_valid_m[set_idx] && i_tag_m[set_idx] == tag);
            i_valid_m[set_idx] = 1'b1;
            i_tag_m[set_idx]   = tag;
        end else begin
            hit = 32'(d_valid_m[set_idx] && d_tag_m[set_idx] == tag);
            d_valid_m[set_idx] = 1'b1;
            d_tag_m[set_idx]   = tag;
        end
        for (int b = 0; b < 4; b++) begin
            if (acc.op == "W" && acc.mask[b])
                ref_mem[idx][b*8 +: 8] = acc.wdata[b*8 +: 8];
        end
        check_value($sformatf("golden file line %0d word", acc.line_no), ref_mem[idx], acc.word);
        check_value($sformatf("golden file line %0d hit", acc.line_no), hit, acc.hit);
    endtask

    // call on a falling edge; returns on the falling edge of the last resp
    task automatic run_access(input access_t ia, input bit i_en, input access_t da,
                              input bit d_en, output logic [31:0] i_word,
                              output logic [31:0] i_hit, output logic [31:0] i_miss,
                              output logic [31:0] d_word, output logic [31:0] d_hit,
                              output logic [31:0] d_miss, output int cycles);
        bit i_wait;
        bit d_wait;
        i_wait = i_en;
        d_wait = d_en;
        i_hit  = 0;
        i_miss = 0;
        d_hit  = 0;
        d_miss = 0;
        cycles = 0;
        if (i_en) begin
            imem_address_i = ia.addr;
            imem_read_i    = 1'b1;
        end
        if (d_en) begin
            dmem_address_i = da.addr;
            dmem_wdata_i   = da.wdata;
            dmem_wmask_i   = da.mask;
            dmem_read_i    = (da.op != "W");
            dmem_write_i   = (da.op == "W");
        end
        while (i_wait || d_wait) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                fail_run("no response from the DUT within 500 cycles");
            if (i_hit_o)
                i_hit = 1;
            if (i_miss_o)
                i_miss = 1;
            if (d_hit_o)
                d_hit = 1;
            if (d_miss_o)
                d_miss = 1;
            if (i_wait && imem_resp_o) begin
                i_word      = imem_rdata_o;
                imem_read_i = 1'b0;
                i_wait      = 0;
            end
            if (d_wait && dmem_resp_o) begin
                d_word       = dmem_rdata_o;
                dmem_read_i  = 1'b0;
                dmem_write_i = 1'b0;
                d_wait       = 0;
            end
        end
    endtask

    initial begin
        access_t     acc;
        access_t     pair;
        logic [31:0] i_word, i_hit, d_word, d_hit;
        logic [31:0] i_miss, d_miss;
        int          cycles;
        int          idx;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i]   = (i * 4) ^ 32'hA5A5_0000;
            ref_mem[i] = (i * 4) ^ 32'hA5A5_0000;
        end
        load_golden();
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        idx = 0;
        while (idx < accesses.size()) begin
            acc = accesses[idx];
            @(negedge clk);
            if (acc.op == "P") begin
                if (idx + 1 >= accesses.size() || accesses[idx + 1].port != "D")
                    fail_run("golden file pairs a fetch with no data access");
                pair = accesses[idx + 1];
                verify_model(acc);
                verify_model(pair);
                run_access(acc, 1, pair, 1, i_word, i_hit, i_miss, d_word, d_hit, d_miss,
                           cycles);
                check_value($sformatf("line %0d imem word", acc.line_no), acc.word, i_word);
                check_value($sformatf("line %0d imem hit", acc.line_no), acc.hit, i_hit);
                check_value($sformatf("line %0d imem miss", acc.line_no),
                            32'(acc.hit == 0), i_miss);
                check_value($sformatf("line %0d dmem word", pair.line_no), pair.word, d_word);
                check_value($sformatf("line %0d dmem hit", pair.line_no), pair.hit, d_hit);
                check_value($sformatf("line %0d dmem miss", pair.line_no),
                            32'(pair.hit == 0), d_miss);
                idx += 2;
            end else begin
                verify_model(acc);
                run_access(acc, acc.port == "I", acc, acc.port == "D",
                           i_word, i_hit, i_miss, d_word, d_hit, d_miss, cycles);
                check_value($sformatf("line %0d word", acc.line_no), acc.word,
                            (acc.port == "I") ? i_word : d_word);
                check_value($sformatf("line %0d hit", acc.line_no), acc.hit,
                            (acc.port == "I") ? i_hit : d_hit);
                check_value($sformatf("line %0d miss", acc.line_no), 32'(acc.hit == 0),
                            (acc.port == "I") ? i_miss : d_miss);
                if (acc.hit != 0)
                    check_value($sformatf("line %0d hit latency", acc.line_no), 2, cycles);
                idx++;
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule : mem_subsystem_tb

// ==== all.f ====
+incdir+hw
hw/cache_types_pkg.sv
hw/mem_bus_pkg.sv
hw/icache.sv
hw/dcache.sv
hw/cache_arbiter.sv
hw/cacheline_adaptor.sv
hw/mem_subsystem.sv
testbench/mem_subsystem_checker.sv
testbench/mem_subsystem_tb.sv

// ==== testbench/mem_subsystem_golden.txt ====
# port (I/D)  op (R, W, or P = fetch issued together with the next data line)
# address  wdata  mask  expected word (all hex)  expected hit (0 miss, 1 hit)
I R 00000100 00000000 0 a5a50100 0
I R 0000010c 00000000 0 a5a5010c 1
D R 00000200 00000000 0 a5a50200 0
D R 00000214 00000000 0 a5a50214 1
D W 00000208 12345678 5 a5340278 1
D R 00000208 00000000 0 a5340278 1
D W 00000424 cafebabe f cafebabe 0
D R 00000824 00000000 0 a5a50824 0
D R 00000424 00000000 0 cafebabe 0
D R 00000000 00000000 0 a5a50000 0
D R 00000208 00000000 0 a5340278 0
I P 00000300 00000000 0 a5a50300 0
D R 00000344 00000000 0 a5a50344 0
I R 00000104 00000000 0 a5a50104 0
I R 00000304 00000000 0 a5a50304 0
I R 00000108 00000000 0 a5a50108 0
I R 00000110 00000000 0 a5a50110 1
I R 00000504 00000000 0 a5a50504 0
I R 00000114 00000000 0 a5a50114 0
